// File: Bender.yml
package:
  name: axi_demux

sources:
  - src/demux_pkg.sv
  - src/id_track_if.sv
  - src/id_tracker.sv
  - src/aw_steer.sv
  - src/ar_steer.sv
  - src/resp_arbiter.sv
  - src/axi_demux_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_demux.sv

// File: sim/tb_clock.sv
// clock and synchronous reset source for the testbench
// 100 ns period, reset released on the 10th rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // low from time zero, released on a rising edge like any other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_demux.sv
// random AXI-style traffic through the 1-to-4 demux with four master models
// masters answer B with resp = port and R with data = addr + port, addr[1:0]+1 beats
`timescale 1ns/1ps
`default_nettype none

module tb_demux import demux_pkg::*; ();

  localparam int N_WR         = 200;
  localparam int N_RD         = 200;
  localparam int TIMEOUT      = (N_WR + N_RD) * 64;
  localparam int NUM_FULL_IDS = 2 ** ID_W;

  logic clk_i;
  logic rst_n_i;
  // slave side
  logic  s_aw_valid_i, s_aw_ready_o;
  id_t   s_aw_id_i;
  addr_t s_aw_addr_i;
  sel_t  s_aw_sel_i;
  logic  s_w_valid_i, s_w_ready_o, s_w_last_i;
  data_t s_w_data_i;
  logic  s_b_valid_o, s_b_ready_i;
  id_t   s_b_id_o;
  resp_t s_b_resp_o;
  logic  s_ar_valid_i, s_ar_ready_o;
  id_t   s_ar_id_i;
  addr_t s_ar_addr_i;
  sel_t  s_ar_sel_i;
  logic  s_r_valid_o, s_r_ready_i, s_r_last_o;
  id_t   s_r_id_o;
  data_t s_r_data_o;
  resp_t s_r_resp_o;
  // master side
  logic  [NUM_PORTS-1:0] m_aw_valid_o, m_aw_ready_i;
  id_t   [NUM_PORTS-1:0] m_aw_id_o;
  addr_t [NUM_PORTS-1:0] m_aw_addr_o;
  logic  [NUM_PORTS-1:0] m_w_valid_o, m_w_ready_i, m_w_last_o;
  data_t [NUM_PORTS-1:0] m_w_data_o;
  logic  [NUM_PORTS-1:0] m_b_valid_i, m_b_ready_o;
  id_t   [NUM_PORTS-1:0] m_b_id_i;
  resp_t [NUM_PORTS-1:0] m_b_resp_i;
  logic  [NUM_PORTS-1:0] m_ar_valid_o, m_ar_ready_i;
  id_t   [NUM_PORTS-1:0] m_ar_id_o;
  addr_t [NUM_PORTS-1:0] m_ar_addr_o;
  logic  [NUM_PORTS-1:0] m_r_valid_i, m_r_ready_o, m_r_last_i;
  id_t   [NUM_PORTS-1:0] m_r_id_i;
  data_t [NUM_PORTS-1:0] m_r_data_i;
  resp_t [NUM_PORTS-1:0] m_r_resp_i;

  integer seed = 24645;
  int     errors;
  int     cycles;
  int     aw_sent;
  int     ar_sent;
  int     b_done;
  int     r_done;
  int     aw_len;
  // W beats still to send, in AW order, {port, last, data}
  logic [34:0] w_beats[$];
  // master models
  id_t         aw_ids[NUM_PORTS][$];
  int          w_done[NUM_PORTS];
  id_t         b_pend[NUM_PORTS][$];
  logic [19:0] ar_pend[NUM_PORTS][$];
  int          r_beat[NUM_PORTS];
  // open transactions per kind (0 write, 1 read), port and full ID
  int          open_cnt[2][NUM_PORTS][NUM_FULL_IDS];
  // reads per ID in master order, {port, addr}
  logic [17:0] rd_exp[NUM_FULL_IDS][$];
  int          rd_beat[NUM_FULL_IDS];
  // handshakes seen at the last falling edge
  logic aw_hs, w_hs, ar_hs;
  logic [NUM_PORTS-1:0] b_hs_m, r_hs_m;
  // offers that waited last cycle and what they must still show
  logic [NUM_PORTS-1:0]       aw_wait, ar_wait, w_wait;
  logic [NUM_PORTS-1:0][20:0] aw_hold, ar_hold;
  logic [NUM_PORTS-1:0][33:0] w_hold;
  logic                       b_wait, r_wait;
  logic [6:0]                 b_hold;
  logic [39:0]                r_hold;

  tb_clock u_clock (.clk_o(clk_i), .rst_n_o(rst_n_i));

  axi_demux_top DUT (.*);

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  task automatic check_equal(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // each port ready about three cycles in four
  function automatic logic [NUM_PORTS-1:0] ready_mask();
    return NUM_PORTS'($random(seed) | $random(seed));
  endfunction

  // a tracked ID may be open at one port only
  task automatic check_one_port(input int kind);
    logic [NUM_PORTS-1:0] used;
    for (int lo = 0; lo < NUM_IDS; lo++) begin
      used = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        for (int id = lo; id < NUM_FULL_IDS; id += NUM_IDS) begin
          if (open_cnt[kind][p][id] > 0) used[p] = 1'b1;
        end
      end
      if ($countones(used) > 1) begin
        report_error($sformatf("%s ID %0d is open at more than one port",
                               (kind == 0) ? "write" : "read", lo));
      end
    end
  endtask

  //--------------------------------------------------------------------
  // sampling at the falling edge, everything is settled here
  //--------------------------------------------------------------------
  task automatic monitor();
    int          n_hs;
    int          port;
    id_t         id;
    logic [17:0] e;
    logic        exp_last;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (aw_wait[p]) begin
        check_equal("aw_hold", aw_hold[p], {m_aw_valid_o[p], m_aw_id_o[p], m_aw_addr_o[p]});
      end
      if (ar_wait[p]) begin
        check_equal("ar_hold", ar_hold[p], {m_ar_valid_o[p], m_ar_id_o[p], m_ar_addr_o[p]});
      end
      if (w_wait[p]) begin
        check_equal("w_hold", w_hold[p], {m_w_valid_o[p], m_w_last_o[p], m_w_data_o[p]});
      end
      aw_wait[p] = m_aw_valid_o[p] && !m_aw_ready_i[p];
      aw_hold[p] = {1'b1, m_aw_id_o[p], m_aw_addr_o[p]};
      ar_wait[p] = m_ar_valid_o[p] && !m_ar_ready_i[p];
      ar_hold[p] = {1'b1, m_ar_id_o[p], m_ar_addr_o[p]};
      w_wait[p]  = m_w_valid_o[p] && !m_w_ready_i[p];
      w_hold[p]  = {1'b1, m_w_last_o[p], m_w_data_o[p]};
    end
    if (b_wait) check_equal("b_hold", b_hold, {s_b_valid_o, s_b_id_o, s_b_resp_o});
    if (r_wait) begin
      check_equal("r_hold", r_hold,
                  {s_r_valid_o, s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o});
    end
    b_wait = s_b_valid_o && !s_b_ready_i;
    b_hold = {1'b1, s_b_id_o, s_b_resp_o};
    r_wait = s_r_valid_o && !s_r_ready_i;
    r_hold = {1'b1, s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o};

    // AW reaches the selected port unchanged
    aw_hs = s_aw_valid_i && s_aw_ready_o;
    n_hs  = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
        n_hs++;
        check_equal("aw_port", s_aw_sel_i, p);
        check_equal("aw_id", s_aw_id_i, m_aw_id_o[p]);
        check_equal("aw_addr", s_aw_addr_i, m_aw_addr_o[p]);
        aw_ids[p].push_back(m_aw_id_o[p]);
        open_cnt[0][p][m_aw_id_o[p]]++;
      end
    end
    check_equal("aw_handshakes", aw_hs, n_hs);
    if (aw_hs) begin
      aw_sent++;
      for (int k = 0; k < aw_len; k++) begin
        w_beats.push_back({s_aw_sel_i, (k == aw_len - 1), data_t'($random(seed))});
      end
    end

    // W follows the port of its AW
    w_hs = s_w_valid_i && s_w_ready_o;
    n_hs = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (m_w_valid_o[p] && m_w_ready_i[p]) begin
        n_hs++;
        check_equal("w_port", w_beats[0][34:33], p);
        check_equal("w_data", w_beats[0][31:0], m_w_data_o[p]);
        check_equal("w_last", w_beats[0][32], m_w_last_o[p]);
        if (m_w_last_o[p]) w_done[p]++;
      end
    end
    check_equal("w_handshakes", w_hs, n_hs);
    if (w_hs) void'(w_beats.pop_front());

    // a write may answer once both its AW and its last W arrived
    for (int p = 0; p < NUM_PORTS; p++) begin
      while (aw_ids[p].size() > 0 && w_done[p] > 0) begin
        b_pend[p].push_back(aw_ids[p].pop_front());
        w_done[p]--;
      end
      b_hs_m[p] = m_b_valid_i[p] && m_b_ready_o[p];
      if (b_hs_m[p]) void'(b_pend[p].pop_front());
    end
    check_equal("b_handshakes", s_b_valid_o && s_b_ready_i, $countones(b_hs_m));
    if (s_b_valid_o && s_b_ready_i) begin
      port = -1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port < 0 && open_cnt[0][p][s_b_id_o] > 0) port = p;
      end
      if (port < 0) begin
        report_error($sformatf("B with ID %0h is not open at any port", s_b_id_o));
      end else begin
        check_equal("b_resp", resp_t'(port), s_b_resp_o);
        open_cnt[0][port][s_b_id_o]--;
      end
      b_done++;
    end

    // AR reaches the selected port unchanged
    ar_hs = s_ar_valid_i && s_ar_ready_o;
    n_hs  = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (m_ar_valid_o[p] && m_ar_ready_i[p]) begin
        n_hs++;
        check_equal("ar_port", s_ar_sel_i, p);
        check_equal("ar_id", s_ar_id_i, m_ar_id_o[p]);
        check_equal("ar_addr", s_ar_addr_i, m_ar_addr_o[p]);
        ar_pend[p].push_back({m_ar_id_o[p], m_ar_addr_o[p]});
        open_cnt[1][p][m_ar_id_o[p]]++;
        rd_exp[m_ar_id_o[p]].push_back({sel_t'(p), m_ar_addr_o[p]});
      end
    end
    check_equal("ar_handshakes", ar_hs, n_hs);
    if (ar_hs) ar_sent++;

    for (int p = 0; p < NUM_PORTS; p++) begin
      r_hs_m[p] = m_r_valid_i[p] && m_r_ready_o[p];
      if (r_hs_m[p] && m_r_last_i[p]) begin
        void'(ar_pend[p].pop_front());
        r_beat[p] = 0;
      end else if (r_hs_m[p]) begin
        r_beat[p]++;
      end
    end
    check_equal("r_handshakes", s_r_valid_o && s_r_ready_i, $countones(r_hs_m));
    if (s_r_valid_o && s_r_ready_i) begin
      id = s_r_id_o;
      if (rd_exp[id].size() == 0) begin
        report_error($sformatf("R with ID %0h is not open at any port", id));
      end else begin
        e        = rd_exp[id][0];
        exp_last = (rd_beat[id] == int'(e[1:0]));
        check_equal("r_data", data_t'(e[15:0]) + data_t'(e[17:16]), s_r_data_o);
        check_equal("r_last", exp_last, s_r_last_o);
        check_equal("r_resp", '0, s_r_resp_o);
        if (exp_last) begin
          void'(rd_exp[id].pop_front());
          rd_beat[id] = 0;
          open_cnt[1][e[17:16]][id]--;
          r_done++;
        end else begin
          rd_beat[id]++;
        end
      end
    end

    check_one_port(0);
    check_one_port(1);
  endtask

  //--------------------------------------------------------------------
  // stimulus on the rising edge
  //--------------------------------------------------------------------
  task automatic drive();
    logic        stall;
    logic [19:0] rd;
    // every ready low for 64 cycles out of 512
    stall = ((cycles / 64) % 8) == 7;

    if (aw_hs || !s_aw_valid_i) begin
      if (aw_sent < N_WR && rand_below(3) != 0) begin
        aw_len = 1 + rand_below(4);
        s_aw_valid_i <= 1'b1;
        s_aw_id_i    <= id_t'(rand_below(NUM_FULL_IDS));
        s_aw_sel_i   <= sel_t'(rand_below(NUM_PORTS));
        s_aw_addr_i  <= addr_t'($random(seed));
      end else begin
        s_aw_valid_i <= 1'b0;
      end
    end
    if (w_hs || !s_w_valid_i) begin
      if (w_beats.size() > 0 && rand_below(4) != 0) begin
        s_w_valid_i <= 1'b1;
        s_w_data_i  <= w_beats[0][31:0];
        s_w_last_i  <= w_beats[0][32];
      end else begin
        s_w_valid_i <= 1'b0;
      end
    end
    if (ar_hs || !s_ar_valid_i) begin
      if (ar_sent < N_RD && rand_below(3) != 0) begin
        s_ar_valid_i <= 1'b1;
        s_ar_id_i    <= id_t'(rand_below(NUM_FULL_IDS));
        s_ar_sel_i   <= sel_t'(rand_below(NUM_PORTS));
        s_ar_addr_i  <= addr_t'($random(seed));
      end else begin
        s_ar_valid_i <= 1'b0;
      end
    end

    m_aw_ready_i <= stall ? '0 : ready_mask();
    m_w_ready_i  <= stall ? '0 : ready_mask();
    m_ar_ready_i <= stall ? '0 : ready_mask();
    s_b_ready_i  <= !stall && (rand_below(4) != 0);
    s_r_ready_i  <= !stall && (rand_below(4) != 0);

    // responders keep valid and payload until their handshake
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (b_hs_m[p] || !m_b_valid_i[p]) begin
        if (b_pend[p].size() > 0 && rand_below(4) != 0) begin
          m_b_valid_i[p] <= 1'b1;
          m_b_id_i[p]    <= b_pend[p][0];
          m_b_resp_i[p]  <= resp_t'(p);
        end else begin
          m_b_valid_i[p] <= 1'b0;
        end
      end
      if (r_hs_m[p] || !m_r_valid_i[p]) begin
        if (ar_pend[p].size() > 0 && rand_below(4) != 0) begin
          rd = ar_pend[p][0];
          m_r_valid_i[p] <= 1'b1;
          m_r_id_i[p]    <= rd[19:16];
          m_r_data_i[p]  <= data_t'(rd[15:0]) + data_t'(p);
          m_r_resp_i[p]  <= '0;
          m_r_last_i[p]  <= (r_beat[p] == int'(rd[1:0]));
        end else begin
          m_r_valid_i[p] <= 1'b0;
        end
      end
    end
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial begin
    s_aw_valid_i = 1'b0;
    s_aw_id_i    = '0;
    s_aw_addr_i  = '0;
    s_aw_sel_i   = '0;
    s_w_valid_i  = 1'b0;
    s_w_data_i   = '0;
    s_w_last_i   = 1'b0;
    s_b_ready_i  = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_sel_i   = '0;
    s_r_ready_i  = 1'b0;
    m_aw_ready_i = '0;
    m_w_ready_i  = '0;
    m_b_valid_i  = '0;
    m_b_id_i     = '0;
    m_b_resp_i   = '0;
    m_ar_ready_i = '0;
    m_r_valid_i  = '0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    m_r_last_i   = '0;
    aw_wait      = '0;
    ar_wait      = '0;
    w_wait       = '0;
    b_wait       = 1'b0;
    r_wait       = 1'b0;

    // registers only clear on a clock edge, so start sampling after the first one
    @(posedge clk_i);

    while (!(b_done == N_WR && r_done == N_RD) && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      if (!rst_n_i) begin
        // registers cleared and inputs idle, so every valid and ready is low
        check_equal("reset_idle", '0,
                    {s_aw_ready_o, s_w_ready_o, s_b_valid_o, s_ar_ready_o, s_r_valid_o,
                     m_aw_valid_o, m_w_valid_o, m_b_ready_o, m_ar_valid_o, m_r_ready_o});
      end else begin
        monitor();
        @(posedge clk_i);
        drive();
      end
    end

    if (b_done != N_WR || r_done != N_RD) begin
      report_error($sformatf("timeout after %0d cycles with %0d writes and %0d reads done",
                             cycles, b_done, r_done));
    end
    $display("summary: %0d errors, %0d writes, %0d reads, %0d cycles",
             errors, b_done, r_done, cycles);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/demux_pkg.sv
src/id_track_if.sv
src/id_tracker.sv
src/aw_steer.sv
src/ar_steer.sv
src/resp_arbiter.sv
src/axi_demux_top.sv
sim/tb_clock.sv
sim/tb_demux.sv

// File: src/ar_steer.sv
// AR admission against the read ID tracker with a valid lock
// the tracker is pushed on the AR handshake
`timescale 1ns/1ps
`default_nettype none

module ar_steer import demux_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 ar_valid_i,
  input  sel_t                 ar_sel_i,
  input  id_t                  ar_id_i,
  output logic                 ar_ready_o,
  output logic [NUM_PORTS-1:0] mst_ar_valid_o,
  input  logic [NUM_PORTS-1:0] mst_ar_ready_i,
  id_track_if.steer            trk
);

  logic lock_q;
  logic ar_valid;

  assign trk.lookup_id = ar_id_i[LOOK_BITS-1:0];
  assign trk.push_id   = ar_id_i[LOOK_BITS-1:0];
  assign trk.push_sel  = ar_sel_i;

  // locked offers skip the checks, the tracker can only have drained meanwhile
  assign ar_valid = lock_q ||
                    (ar_valid_i && !trk.full &&
                     (!trk.lookup_busy || (trk.lookup_sel == ar_sel_i)));

  assign ar_ready_o = ar_valid && mst_ar_ready_i[ar_sel_i];
  assign trk.push   = ar_ready_o;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      mst_ar_valid_o[i] = ar_valid && (ar_sel_i == sel_t'(i));
    end
  end

  // hold the offer while the master stalls
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= ar_valid && !mst_ar_ready_i[ar_sel_i];
    end
  end

  // the offer must stay on the same port until the master takes it
  a_ar_valid_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (ar_valid && !ar_ready_o) |=> $stable(mst_ar_valid_o)
  ) else $error("AR valid dropped or moved before ready");

endmodule

`default_nettype wire

// File: src/aw_steer.sv
// AW admission, AW valid lock and W routing by open-burst count
// W bursts must arrive in AW order and must not interleave
`timescale 1ns/1ps
`default_nettype none

module aw_steer import demux_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // slave AW
  input  logic                 aw_valid_i,
  input  sel_t                 aw_sel_i,
  input  id_t                  aw_id_i,
  output logic                 aw_ready_o,
  // master AW
  output logic [NUM_PORTS-1:0] mst_aw_valid_o,
  input  logic [NUM_PORTS-1:0] mst_aw_ready_i,
  // slave W
  input  logic                 w_valid_i,
  input  logic                 w_last_i,
  output logic                 w_ready_o,
  // master W
  output logic [NUM_PORTS-1:0] mst_w_valid_o,
  input  logic [NUM_PORTS-1:0] mst_w_ready_i,
  id_track_if.steer            trk
);

  logic lock_q;
  logic lock_d;
  logic aw_valid;
  logic w_cnt_up;
  logic w_cnt_down;
  logic w_sel_valid;
  cnt_t w_open_q;
  sel_t w_sel_q;
  sel_t w_sel;

  assign trk.lookup_id = aw_id_i[LOOK_BITS-1:0];
  assign trk.push_id   = aw_id_i[LOOK_BITS-1:0];
  assign trk.push_sel  = aw_sel_i;
  // push once, on the first cycle the AW is offered
  assign trk.push      = w_cnt_up;

  //----------------------------------------------------------------------
  // AW admission and lock
  //----------------------------------------------------------------------
  always_comb begin
    aw_valid = 1'b0;
    w_cnt_up = 1'b0;
    lock_d   = lock_q;
    if (lock_q) begin
      // decision already taken, keep offering until the master takes it
      aw_valid = 1'b1;
      if (mst_aw_ready_i[aw_sel_i]) begin
        lock_d = 1'b0;
      end
    end else if (aw_valid_i && !trk.full && (w_open_q != CNT_FULL) &&
                 ((w_open_q == '0) || (w_sel_q == aw_sel_i)) &&
                 (!trk.lookup_busy || (trk.lookup_sel == aw_sel_i))) begin
      aw_valid = 1'b1;
      w_cnt_up = 1'b1;
      if (!mst_aw_ready_i[aw_sel_i]) begin
        lock_d = 1'b1;
      end
    end
  end

  assign aw_ready_o = aw_valid && mst_aw_ready_i[aw_sel_i];

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      mst_aw_valid_o[i] = aw_valid && (aw_sel_i == sel_t'(i));
    end
  end

  //----------------------------------------------------------------------
  // W routing
  //----------------------------------------------------------------------
  // with no burst open the W may follow the AW offered right now
  assign w_sel       = (w_open_q != '0) ? w_sel_q : aw_sel_i;
  assign w_sel_valid = w_cnt_up || (w_open_q != '0);
  assign w_ready_o   = w_sel_valid && mst_w_ready_i[w_sel];
  assign w_cnt_down  = w_valid_i && w_ready_o && w_last_i;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      mst_w_valid_o[i] = w_sel_valid && w_valid_i && (w_sel == sel_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q   <= 1'b0;
      w_open_q <= '0;
    end else begin
      lock_q <= lock_d;
      if (w_cnt_up && !w_cnt_down) begin
        w_open_q <= w_open_q + cnt_t'(1);
      end else if (w_cnt_down && !w_cnt_up) begin
        w_open_q <= w_open_q - cnt_t'(1);
      end
    end
  end

  // port of the bursts still open
  always_ff @(posedge clk_i) begin
    if (w_cnt_up) begin
      w_sel_q <= aw_sel_i;
    end
  end

  //----------------------------------------------------------------------
  // checks
  //----------------------------------------------------------------------
  // the offer must stay on the same port until the master takes it
  a_aw_valid_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (aw_valid && !aw_ready_o) |=> $stable(mst_aw_valid_o)
  ) else $error("AW valid dropped or moved before ready");

  // a wrap below zero would show up as a full count
  a_w_no_underflow : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (w_open_q == '0) |=> (w_open_q <= cnt_t'(1))
  ) else $error("open W counter underflow");

endmodule

`default_nettype wire

// File: src/axi_demux_top.sv
// one slave port to four master ports, AW/AR steered by their select inputs
// selects must stay stable with their valid, responses merge round-robin
`timescale 1ns/1ps
`default_nettype none

module axi_demux_top import demux_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // slave AW
  input  logic                          s_aw_valid_i,
  output logic                          s_aw_ready_o,
  input  id_t                           s_aw_id_i,
  input  addr_t                         s_aw_addr_i,
  input  sel_t                          s_aw_sel_i,
  // slave W
  input  logic                          s_w_valid_i,
  output logic                          s_w_ready_o,
  input  data_t                         s_w_data_i,
  input  logic                          s_w_last_i,
  // slave B
  output logic                          s_b_valid_o,
  input  logic                          s_b_ready_i,
  output id_t                           s_b_id_o,
  output resp_t                         s_b_resp_o,
  // slave AR
  input  logic                          s_ar_valid_i,
  output logic                          s_ar_ready_o,
  input  id_t                           s_ar_id_i,
  input  addr_t                         s_ar_addr_i,
  input  sel_t                          s_ar_sel_i,
  // slave R
  output logic                          s_r_valid_o,
  input  logic                          s_r_ready_i,
  output id_t                           s_r_id_o,
  output data_t                         s_r_data_o,
  output resp_t                         s_r_resp_o,
  output logic                          s_r_last_o,
  // master AW
  output logic  [NUM_PORTS-1:0]         m_aw_valid_o,
  input  logic  [NUM_PORTS-1:0]         m_aw_ready_i,
  output id_t   [NUM_PORTS-1:0]         m_aw_id_o,
  output addr_t [NUM_PORTS-1:0]         m_aw_addr_o,
  // master W
  output logic  [NUM_PORTS-1:0]         m_w_valid_o,
  input  logic  [NUM_PORTS-1:0]         m_w_ready_i,
  output data_t [NUM_PORTS-1:0]         m_w_data_o,
  output logic  [NUM_PORTS-1:0]         m_w_last_o,
  // master B
  input  logic  [NUM_PORTS-1:0]         m_b_valid_i,
  output logic  [NUM_PORTS-1:0]         m_b_ready_o,
  input  id_t   [NUM_PORTS-1:0]         m_b_id_i,
  input  resp_t [NUM_PORTS-1:0]         m_b_resp_i,
  // master AR
  output logic  [NUM_PORTS-1:0]         m_ar_valid_o,
  input  logic  [NUM_PORTS-1:0]         m_ar_ready_i,
  output id_t   [NUM_PORTS-1:0]         m_ar_id_o,
  output addr_t [NUM_PORTS-1:0]         m_ar_addr_o,
  // master R
  input  logic  [NUM_PORTS-1:0]         m_r_valid_i,
  output logic  [NUM_PORTS-1:0]         m_r_ready_o,
  input  id_t   [NUM_PORTS-1:0]         m_r_id_i,
  input  data_t [NUM_PORTS-1:0]         m_r_data_i,
  input  resp_t [NUM_PORTS-1:0]         m_r_resp_i,
  input  logic  [NUM_PORTS-1:0]         m_r_last_i
);

  id_track_if trk_aw ();
  id_track_if trk_ar ();

  logic [NUM_PORTS-1:0][B_PAY_W-1:0] b_pay;
  logic [NUM_PORTS-1:0][R_PAY_W-1:0] r_pay;
  logic [B_PAY_W-1:0]                b_pay_out;
  logic [R_PAY_W-1:0]                r_pay_out;

  //----------------------------------------------------------------------
  // payload fan-out and response packing
  //----------------------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign m_aw_id_o[i]   = s_aw_id_i;
    assign m_aw_addr_o[i] = s_aw_addr_i;
    assign m_w_data_o[i]  = s_w_data_i;
    assign m_w_last_o[i]  = s_w_last_i;
    assign m_ar_id_o[i]   = s_ar_id_i;
    assign m_ar_addr_o[i] = s_ar_addr_i;
    assign b_pay[i]       = {m_b_id_i[i], m_b_resp_i[i]};
    assign r_pay[i]       = {m_r_id_i[i], m_r_data_i[i], m_r_resp_i[i], m_r_last_i[i]};
  end

  assign {s_b_id_o, s_b_resp_o}                         = b_pay_out;
  assign {s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o} = r_pay_out;

  // pops on the slave side handshakes, reads retire on the last beat
  assign trk_aw.pop_id = s_b_id_o[LOOK_BITS-1:0];
  assign trk_aw.pop    = s_b_valid_o && s_b_ready_i;
  assign trk_ar.pop_id = s_r_id_o[LOOK_BITS-1:0];
  assign trk_ar.pop    = s_r_valid_o && s_r_ready_i && s_r_last_o;

  //----------------------------------------------------------------------
  // instances
  //----------------------------------------------------------------------
  aw_steer u_aw_steer (
    .clk_i, .rst_n_i,
    .aw_valid_i     (s_aw_valid_i),
    .aw_sel_i       (s_aw_sel_i),
    .aw_id_i        (s_aw_id_i),
    .aw_ready_o     (s_aw_ready_o),
    .mst_aw_valid_o (m_aw_valid_o),
    .mst_aw_ready_i (m_aw_ready_i),
    .w_valid_i      (s_w_valid_i),
    .w_last_i       (s_w_last_i),
    .w_ready_o      (s_w_ready_o),
    .mst_w_valid_o  (m_w_valid_o),
    .mst_w_ready_i  (m_w_ready_i),
    .trk            (trk_aw.steer)
  );

  ar_steer u_ar_steer (
    .clk_i, .rst_n_i,
    .ar_valid_i     (s_ar_valid_i),
    .ar_sel_i       (s_ar_sel_i),
    .ar_id_i        (s_ar_id_i),
    .ar_ready_o     (s_ar_ready_o),
    .mst_ar_valid_o (m_ar_valid_o),
    .mst_ar_ready_i (m_ar_ready_i),
    .trk            (trk_ar.steer)
  );

  id_tracker u_aw_tracker (.clk_i, .rst_n_i, .trk(trk_aw.tracker));
  id_tracker u_ar_tracker (.clk_i, .rst_n_i, .trk(trk_ar.tracker));

  resp_arbiter #(.PAYLOAD_W(B_PAY_W)) u_b_arb (
    .clk_i, .rst_n_i,
    .in_valid_i    (m_b_valid_i),
    .in_payload_i  (b_pay),
    .in_ready_o    (m_b_ready_o),
    .out_valid_o   (s_b_valid_o),
    .out_payload_o (b_pay_out),
    .out_ready_i   (s_b_ready_i)
  );

  resp_arbiter #(.PAYLOAD_W(R_PAY_W)) u_r_arb (
    .clk_i, .rst_n_i,
    .in_valid_i    (m_r_valid_i),
    .in_payload_i  (r_pay),
    .in_ready_o    (m_r_ready_o),
    .out_valid_o   (s_r_valid_o),
    .out_payload_o (r_pay_out),
    .out_ready_i   (s_r_ready_i)
  );

endmodule

`default_nettype wire

// File: src/demux_pkg.sv
// widths and payload types shared by the 1-to-4 demux
// the port count is fixed at 4 and trackers only look at the low ID bits
`default_nettype none

package demux_pkg;

  //----------------------------------------------------------------------
  // sizes
  //----------------------------------------------------------------------
  localparam int unsigned NUM_PORTS = 4;
  localparam int unsigned SEL_W     = 2;
  localparam int unsigned ID_W      = 4;
  // low ID bits used by the trackers, one counter per value
  localparam int unsigned LOOK_BITS = 2;
  localparam int unsigned NUM_IDS   = 2 ** LOOK_BITS;
  // in-flight counters, all ones means full
  localparam int unsigned CNT_W     = 3;
  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned DATA_W    = 32;

  //----------------------------------------------------------------------
  // types
  //----------------------------------------------------------------------
  typedef logic [SEL_W-1:0]     sel_t;
  typedef logic [ID_W-1:0]      id_t;
  typedef logic [LOOK_BITS-1:0] look_t;
  typedef logic [CNT_W-1:0]     cnt_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [1:0]           resp_t;

  // a count of 7 blocks further pushes
  localparam cnt_t CNT_FULL = '1;

  // packed response payloads fed to the arbiters
  // B is {id, resp}, R is {id, data, resp, last}
  localparam int unsigned B_PAY_W = ID_W + 2;
  localparam int unsigned R_PAY_W = ID_W + DATA_W + 2 + 1;

endpackage

`default_nettype wire

// File: src/id_track_if.sv
// lookup, push and pop between a steering block and its ID tracker
// pop is driven from the response side in the top level
`timescale 1ns/1ps
`default_nettype none

interface id_track_if import demux_pkg::*; ();

  // lookup of the ID currently offered
  look_t lookup_id;
  sel_t  lookup_sel;
  logic  lookup_busy;
  logic  full;

  // new transaction
  look_t push_id;
  sel_t  push_sel;
  logic  push;

  // retired transaction
  look_t pop_id;
  logic  pop;

  modport steer (
    output lookup_id, push_id, push_sel, push,
    input  lookup_sel, lookup_busy, full
  );

  modport tracker (
    input  lookup_id, push_id, push_sel, push, pop_id, pop,
    output lookup_sel, lookup_busy, full
  );

endinterface

`default_nettype wire

// File: src/id_tracker.sv
// per-ID in-flight counters with the port select of the open transactions
// full rises as soon as any one counter reaches 7
`timescale 1ns/1ps
`default_nettype none

module id_tracker import demux_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  id_track_if.tracker trk
);

  // in-flight count and remembered port per tracked ID
  cnt_t cnt_q [NUM_IDS];
  sel_t sel_q [NUM_IDS];

  logic [NUM_IDS-1:0] busy;
  logic [NUM_IDS-1:0] at_max;

  //----------------------------------------------------------------------
  // lookup
  //----------------------------------------------------------------------
  assign trk.lookup_sel  = sel_q[trk.lookup_id];
  assign trk.lookup_busy = busy[trk.lookup_id];
  assign trk.full        = |at_max;

  //----------------------------------------------------------------------
  // counters
  //----------------------------------------------------------------------
  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_cnt
    logic push_en;
    logic pop_en;

    assign push_en   = trk.push && (trk.push_id == look_t'(i));
    assign pop_en    = trk.pop && (trk.pop_id == look_t'(i));
    assign busy[i]   = (cnt_q[i] != '0);
    assign at_max[i] = (cnt_q[i] == CNT_FULL);

    // push and pop in the same cycle leave the count alone
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (push_en && !pop_en) begin
        cnt_q[i] <= cnt_q[i] + cnt_t'(1);
      end else if (pop_en && !push_en) begin
        cnt_q[i] <= cnt_q[i] - cnt_t'(1);
      end
    end

    // select of the newest push, only read while the count is nonzero
    always_ff @(posedge clk_i) begin
      if (push_en) begin
        sel_q[i] <= trk.push_sel;
      end
    end

    // a response retiring an ID nobody sent points to a broken master
    a_no_underflow : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      pop_en |-> busy[i]
    ) else $error("id tracker counter %0d popped while empty", i);
  end

endmodule

`default_nettype wire

// File: src/resp_arbiter.sv
// round-robin merge of one response channel from the master ports
// the grant stays locked while the slave side stalls
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter import demux_pkg::*; #(
  parameter int unsigned PAYLOAD_W = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NUM_PORTS-1:0]                in_valid_i,
  input  logic [NUM_PORTS-1:0][PAYLOAD_W-1:0] in_payload_i,
  output logic [NUM_PORTS-1:0]                in_ready_o,
  output logic                                out_valid_o,
  output logic [PAYLOAD_W-1:0]                out_payload_o,
  input  logic                                out_ready_i
);

  sel_t rr_q;
  sel_t rr_idx;
  sel_t gnt_idx;
  sel_t lock_idx_q;
  logic lock_q;
  logic hs;

  // first valid port at or after the pointer
  always_comb begin
    logic found;
    sel_t cand;
    found  = 1'b0;
    rr_idx = rr_q;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = rr_q + sel_t'(k);
      if (!found && in_valid_i[cand]) begin
        found  = 1'b1;
        rr_idx = cand;
      end
    end
  end

  assign gnt_idx       = lock_q ? lock_idx_q : rr_idx;
  assign out_valid_o   = in_valid_i[gnt_idx];
  assign out_payload_o = out_valid_o ? in_payload_i[gnt_idx] : '0;
  assign hs            = out_valid_o && out_ready_i;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      in_ready_o[i] = hs && (gnt_idx == sel_t'(i));
    end
  end

  //----------------------------------------------------------------------
  // lock-in and pointer
  //----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (hs) begin
      // next search starts after the winner
      rr_q   <= gnt_idx + sel_t'(1);
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

  a_grant_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(gnt_idx))
  ) else $error("response grant moved while waiting");

endmodule

`default_nettype wire
